// File: Makefile
SRCS := $(shell cat sim.f)

all: run

obj_dir/Vtb_apb_uart: sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_apb_uart -f sim.f

run: obj_dir/Vtb_apb_uart
	@out="$$(./obj_dir/Vtb_apb_uart)"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: apb_slave.sv
// APB slave with address decode, LCR and IER storage, access strobes and read mux
`timescale 1ns/1ps
module apb_slave (
    input  logic        clk,
    input  logic        preset_n,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [11:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic [31:0] prdata_o,
    input  logic [7:0]  rdr_i,
    input  logic [5:0]  lsr_i,
    input  logic [2:0]  iir_i,
    output logic [5:0]  lcr_o,
    output logic [2:0]  ier_o,
    output logic [7:0]  tdr_data_o,
    output logic        tdr_write_o,
    output logic        rdr_read_o,
    output logic        lsr_read_o,
    output logic        iir_read_o
);
    logic access, hit_tdr, hit_rdr, hit_lcr, hit_lsr, hit_ier, hit_iir;
    logic bad_access, wr_ok, rd_ok;

    assign access  = psel_i & penable_i;
    assign hit_tdr = (paddr_i == uart_pkg::ADDR_TDR);
    assign hit_rdr = (paddr_i == uart_pkg::ADDR_RDR);
    assign hit_lcr = (paddr_i == uart_pkg::ADDR_LCR);
    assign hit_lsr = (paddr_i == uart_pkg::ADDR_LSR);
    assign hit_ier = (paddr_i == uart_pkg::ADDR_IER);
    assign hit_iir = (paddr_i == uart_pkg::ADDR_IIR);

    // unmapped, or a write to a status register
    assign bad_access = ~(hit_tdr | hit_rdr | hit_lcr | hit_lsr | hit_ier | hit_iir)
                      | (pwrite_i & (hit_rdr | hit_lsr | hit_iir));
    assign wr_ok = access & pwrite_i & ~bad_access;
    assign rd_ok = access & ~pwrite_i & ~bad_access;

    // zero wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access & bad_access;

    assign tdr_data_o  = pwdata_i[7:0];
    assign tdr_write_o = wr_ok & hit_tdr;
    assign rdr_read_o  = rd_ok & hit_rdr;
    assign lsr_read_o  = rd_ok & hit_lsr;
    assign iir_read_o  = rd_ok & hit_iir;

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            lcr_o <= '0;
            ier_o <= '0;
        end else if (wr_ok) begin
            if (hit_lcr) lcr_o <= pwdata_i[5:0];
            if (hit_ier) ier_o <= pwdata_i[2:0];
        end
    end

    always_comb begin
        case (paddr_i)
            uart_pkg::ADDR_RDR: prdata_o = {24'b0, rdr_i};
            uart_pkg::ADDR_LCR: prdata_o = {26'b0, lcr_o};
            uart_pkg::ADDR_LSR: prdata_o = {26'b0, lsr_i};
            uart_pkg::ADDR_IER: prdata_o = {29'b0, ier_o};
            uart_pkg::ADDR_IIR: prdata_o = {29'b0, iir_i};
            default:            prdata_o = '0;
        endcase
    end

endmodule

// File: apb_uart.sv
// APB UART top level wiring the bus slave, baud generator, serial engines and status
`timescale 1ns/1ps
module apb_uart #(
    parameter int SYSTEM_FREQUENCY = 100000000,
    parameter int SAMPLING_RATE    = 16
) (
    input  logic        clk,
    input  logic        preset_n,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [11:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic [31:0] prdata_o,
    output logic        irq_o,
    output logic        tx_o,
    input  logic        rx_i
);
    logic [5:0] lcr;
    logic [2:0] ier, iir;
    logic [7:0] tdr_data, rdr, rx_data;
    logic [5:0] lsr;
    logic       tdr_write, rdr_read, lsr_read;
    logic       sample_tick, bit_tick, tx_busy, tx_done;
    logic       rx_valid, parity_err, frame_err;

    apb_slave u_apb (
        .clk         (clk),
        .preset_n    (preset_n),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .prdata_o    (prdata_o),
        .rdr_i       (rdr),
        .lsr_i       (lsr),
        .iir_i       (iir),
        .lcr_o       (lcr),
        .ier_o       (ier),
        .tdr_data_o  (tdr_data),
        .tdr_write_o (tdr_write),
        .rdr_read_o  (rdr_read),
        .lsr_read_o  (lsr_read),
        // IIR is derived live, a read clears nothing
        .iir_read_o  ()
    );

    baud_generator #(
        .SYSTEM_FREQUENCY (SYSTEM_FREQUENCY),
        .SAMPLING_RATE    (SAMPLING_RATE)
    ) u_baud (
        .clk           (clk),
        .preset_n      (preset_n),
        .baud_sel_i    (lcr[uart_pkg::LCR_BAUD +: 3]),
        .sample_tick_o (sample_tick),
        .bit_tick_o    (bit_tick)
    );

    uart_tx u_tx (
        .clk          (clk),
        .preset_n     (preset_n),
        .bit_tick_i   (bit_tick),
        .tx_start_i   (tdr_write),
        .tx_data_i    (tdr_data),
        .parity_en_i  (lcr[uart_pkg::LCR_PEN]),
        .parity_odd_i (lcr[uart_pkg::LCR_PODD]),
        .stop2_i      (lcr[uart_pkg::LCR_STOP2]),
        .tx_o         (tx_o),
        .tx_busy_o    (tx_busy),
        .tx_done_o    (tx_done)
    );

    uart_rx #(
        .SAMPLING_RATE (SAMPLING_RATE)
    ) u_rx (
        .clk           (clk),
        .preset_n      (preset_n),
        .sample_tick_i (sample_tick),
        .rx_i          (rx_i),
        .parity_en_i   (lcr[uart_pkg::LCR_PEN]),
        .parity_odd_i  (lcr[uart_pkg::LCR_PODD]),
        .stop2_i       (lcr[uart_pkg::LCR_STOP2]),
        .rx_data_o     (rx_data),
        .rx_valid_o    (rx_valid),
        .parity_err_o  (parity_err),
        .frame_err_o   (frame_err)
    );

    line_status_ctrl u_lsc (
        .clk          (clk),
        .preset_n     (preset_n),
        .rx_data_i    (rx_data),
        .rx_valid_i   (rx_valid),
        .parity_err_i (parity_err),
        .frame_err_i  (frame_err),
        .tx_start_i   (tdr_write),
        .tx_done_i    (tx_done),
        .rdr_read_i   (rdr_read),
        .lsr_read_i   (lsr_read),
        .ier_i        (ier),
        .rdr_o        (rdr),
        .lsr_o        (lsr),
        .iir_o        (iir),
        .irq_o        (irq_o)
    );

endmodule

// File: baud_generator.sv
// baud rate divider producing the oversampling tick and the bit tick
`timescale 1ns/1ps
module baud_generator #(
    parameter int SYSTEM_FREQUENCY = 100000000,
    parameter int SAMPLING_RATE    = 16
) (
    input  logic       clk,
    input  logic       preset_n,
    input  logic [2:0] baud_sel_i,
    output logic       sample_tick_o,
    output logic       bit_tick_o
);
    // slowest rate sets the counter width
    localparam int CNT_W = $clog2(SYSTEM_FREQUENCY /
                                  (uart_pkg::BAUD_TABLE[0] * SAMPLING_RATE) + 1);
    localparam int OVS_W = $clog2(SAMPLING_RATE + 1);

    logic [CNT_W-1:0] div_table [8];
    logic [CNT_W-1:0] smp_cnt;
    logic [OVS_W-1:0] ovs_cnt;
    logic [2:0]       sel_q;
    logic             restart;

    for (genvar i = 0; i < 8; i++) begin : g_div
        assign div_table[i] = CNT_W'(SYSTEM_FREQUENCY /
                                     (uart_pkg::BAUD_TABLE[i] * SAMPLING_RATE));
    end

    assign restart       = (baud_sel_i != sel_q);
    assign sample_tick_o = ~restart && (smp_cnt == div_table[baud_sel_i] - 1'b1);
    assign bit_tick_o    = sample_tick_o && (ovs_cnt == OVS_W'(SAMPLING_RATE - 1));

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            sel_q   <= '0;
            smp_cnt <= '0;
            ovs_cnt <= '0;
        end else if (restart) begin
            sel_q   <= baud_sel_i;
            smp_cnt <= '0;
            ovs_cnt <= '0;
        end else if (sample_tick_o) begin
            smp_cnt <= '0;
            ovs_cnt <= bit_tick_o ? '0 : ovs_cnt + 1'b1;
        end else begin
            smp_cnt <= smp_cnt + 1'b1;
        end
    end

endmodule

// File: line_status_ctrl.sv
// receive data register, sticky line status bits and prioritised interrupt id
`timescale 1ns/1ps
module line_status_ctrl (
    input  logic       clk,
    input  logic       preset_n,
    input  logic [7:0] rx_data_i,
    input  logic       rx_valid_i,
    input  logic       parity_err_i,
    input  logic       frame_err_i,
    input  logic       tx_start_i,
    input  logic       tx_done_i,
    input  logic       rdr_read_i,
    input  logic       lsr_read_i,
    input  logic [2:0] ier_i,
    output logic [7:0] rdr_o,
    output logic [5:0] lsr_o,
    output logic [2:0] iir_o,
    output logic       irq_o
);
    logic               tx_done_q, dr_q, pe_q, fe_q, thre_q, oe_q;
    uart_pkg::intr_id_e iir;

    always_ff @(posedge clk) begin
        if (rx_valid_i) rdr_o <= rx_data_i;
    end

    // set has priority over clear throughout
    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            tx_done_q <= 1'b0;
            dr_q      <= 1'b0;
            pe_q      <= 1'b0;
            fe_q      <= 1'b0;
            thre_q    <= 1'b1;
            oe_q      <= 1'b0;
        end else begin
            if (tx_done_i)                  tx_done_q <= 1'b1;
            else if (lsr_read_i)            tx_done_q <= 1'b0;
            if (rx_valid_i)                 dr_q      <= 1'b1;
            else if (rdr_read_i)            dr_q      <= 1'b0;
            if (rx_valid_i && parity_err_i) pe_q      <= 1'b1;
            else if (lsr_read_i)            pe_q      <= 1'b0;
            if (rx_valid_i && frame_err_i)  fe_q      <= 1'b1;
            else if (lsr_read_i)            fe_q      <= 1'b0;
            if (rx_valid_i && dr_q)         oe_q      <= 1'b1;
            else if (lsr_read_i)            oe_q      <= 1'b0;
            if (tx_done_i)                  thre_q    <= 1'b1;
            else if (tx_start_i)            thre_q    <= 1'b0;
        end
    end

    always_comb begin
        lsr_o = '0;
        lsr_o[uart_pkg::LSR_TX_DONE] = tx_done_q;
        lsr_o[uart_pkg::LSR_DR]      = dr_q;
        lsr_o[uart_pkg::LSR_PE]      = pe_q;
        lsr_o[uart_pkg::LSR_FE]      = fe_q;
        lsr_o[uart_pkg::LSR_THRE]    = thre_q;
        lsr_o[uart_pkg::LSR_OE]      = oe_q;
    end

    always_comb begin
        if (ier_i[uart_pkg::IER_RLS] && (pe_q || fe_q || oe_q)) iir = uart_pkg::INTR_RLS;
        else if (ier_i[uart_pkg::IER_RDA] && dr_q)              iir = uart_pkg::INTR_RDA;
        else if (ier_i[uart_pkg::IER_THRE] && thre_q)           iir = uart_pkg::INTR_THRE;
        else                                                    iir = uart_pkg::INTR_NONE;
    end

    assign iir_o = iir;
    assign irq_o = ~iir[0];

endmodule

// File: sim.f
uart_pkg.sv
apb_slave.sv
baud_generator.sv
uart_tx.sv
uart_rx.sv
line_status_ctrl.sv
apb_uart.sv
uart_properties.sv
uart_checker.sv
tb_apb_uart.sv

// File: tb_apb_uart.sv
// testbench for the APB UART with APB tasks, serial driver, test sequence and timeout
`timescale 1ns/1ps
module tb_apb_uart;
    localparam int SYSTEM_FREQUENCY = 100000000;
    localparam int SAMPLING_RATE    = 16;
    localparam int N_FRAMES         = 37;
    localparam int SLOW_BIT = (SYSTEM_FREQUENCY / (int'(uart_pkg::BAUD_TABLE[6]) * SAMPLING_RATE))
                              * SAMPLING_RATE;
    localparam int CYCLE_LIMIT = N_FRAMES * 12 * SLOW_BIT + 2000;

    logic        clk, preset_n, psel, penable, pwrite, pready, pslverr, irq, tx, rx;
    logic [11:0] paddr;
    logic [31:0] pwdata, prdata;
    logic        drv_line, loop_sel;
    logic [31:0] rng = 32'h0315db67;
    int          bp = SLOW_BIT;
    int          cycles = 0;

    assign rx = loop_sel ? tx : drv_line;

    apb_uart #(.SYSTEM_FREQUENCY(SYSTEM_FREQUENCY), .SAMPLING_RATE(SAMPLING_RATE)) dut_i (
        .clk(clk), .preset_n(preset_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .pready_o(pready), .pslverr_o(pslverr),
        .prdata_o(prdata), .irq_o(irq), .tx_o(tx), .rx_i(rx)
    );

    uart_checker #(.SYSTEM_FREQUENCY(SYSTEM_FREQUENCY), .SAMPLING_RATE(SAMPLING_RATE)) chk_i (
        .clk(clk), .preset_n(preset_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_i(prdata), .pready_i(pready),
        .pslverr_i(pslverr), .irq_i(irq), .tx_i(tx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int bit_cycles(input logic [2:0] sel);
        return (SYSTEM_FREQUENCY / (int'(uart_pkg::BAUD_TABLE[sel]) * SAMPLING_RATE))
               * SAMPLING_RATE;
    endfunction

    function automatic logic [31:0] bit_mask(input int pos);
        return 32'h1 << pos;
    endfunction

    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        rdata = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data, input logic err);
        logic [31:0] unused;
        chk_i.expect_access(1'b1, addr, 32'h0, 32'h0, err);
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [31:0] mask,
                              input logic [31:0] value, input logic err);
        logic [31:0] unused;
        chk_i.expect_access(1'b0, addr, mask, value, err);
        apb_access(1'b0, addr, 32'h0, unused);
    endtask

    task automatic poll_lsr(input int pos);
        logic [31:0] d;
        do apb_access(1'b0, uart_pkg::ADDR_LSR, 32'h0, d);
        while (!d[pos]);
    endtask

    task automatic set_lcr(input logic [5:0] val);
        write_reg(uart_pkg::ADDR_LCR, {26'b0, val}, 1'b0);
        bp = bit_cycles(val[2:0]);
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        drv_line <= b;
        repeat (bp - 1) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic pen, input logic par,
                              input logic stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) drive_bit(data[i]);
        if (pen) drive_bit(par);
        drive_bit(stop);
        drive_bit(1'b1);
    endtask

    task automatic next_byte(output logic [7:0] b);
        rng = xorshift32(rng);
        b   = rng[7:0];
    endtask

    initial begin
        logic [7:0] b, b2;
        logic [5:0] cfg [4];
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        drv_line = 1'b1;
        loop_sel = 1'b1;
        preset_n = 1'b0;
        cfg = '{6'h07, 6'h0F, 6'h1F, 6'h27};
        repeat (2) @(posedge clk);
        preset_n <= 1'b1;

        check_read(uart_pkg::ADDR_LSR, 32'hFFFF_FFFF, 32'h10, 1'b0);
        check_read(uart_pkg::ADDR_IIR, 32'hFFFF_FFFF, 32'h01, 1'b0);
        write_reg(uart_pkg::ADDR_LCR, 32'h2A, 1'b0);
        check_read(uart_pkg::ADDR_LCR, 32'hFFFF_FFFF, 32'h2A, 1'b0);
        write_reg(uart_pkg::ADDR_IER, 32'h5, 1'b0);
        check_read(uart_pkg::ADDR_IER, 32'hFFFF_FFFF, 32'h5, 1'b0);
        write_reg(uart_pkg::ADDR_RDR, 32'h55, 1'b1);
        write_reg(uart_pkg::ADDR_LSR, 32'h3F, 1'b1);
        write_reg(uart_pkg::ADDR_IIR, 32'h7, 1'b1);
        write_reg(12'h018, 32'hFF, 1'b1);
        check_read(12'h01C, 32'hFFFF_FFFF, 32'h0, 1'b1);
        check_read(uart_pkg::ADDR_LCR, 32'hFFFF_FFFF, 32'h2A, 1'b0);
        check_read(uart_pkg::ADDR_IER, 32'hFFFF_FFFF, 32'h5, 1'b0);
        check_read(uart_pkg::ADDR_LSR, 32'hFFFF_FFFF, 32'h10, 1'b0);
        write_reg(uart_pkg::ADDR_IER, 32'h0, 1'b0);
        chk_i.end_test("apb");

        // loopback at baud select 7
        for (int c = 0; c < 4; c++) begin
            set_lcr(cfg[c]);
            for (int k = 0; k < 8; k++) begin
                next_byte(b);
                write_reg(uart_pkg::ADDR_TDR, {24'b0, b}, 1'b0);
                poll_lsr(uart_pkg::LSR_DR);
                check_read(uart_pkg::ADDR_RDR, 32'hFF, {24'b0, b}, 1'b0);
                poll_lsr(uart_pkg::LSR_TX_DONE);
                check_read(uart_pkg::ADDR_LSR, bit_mask(uart_pkg::LSR_DR), 32'h0, 1'b0);
            end
        end
        chk_i.end_test("loopback");

        loop_sel <= 1'b0;
        set_lcr(6'h0E);
        write_reg(uart_pkg::ADDR_IER, bit_mask(uart_pkg::IER_RLS), 1'b0);
        next_byte(b);
        send_frame(b, 1'b1, ~(^b), 1'b1);
        check_read(uart_pkg::ADDR_IIR, 32'h7, 32'h6, 1'b0);
        check_read(uart_pkg::ADDR_LSR, bit_mask(uart_pkg::LSR_PE) | bit_mask(uart_pkg::LSR_DR),
                   bit_mask(uart_pkg::LSR_PE) | bit_mask(uart_pkg::LSR_DR), 1'b0);
        check_read(uart_pkg::ADDR_IIR, 32'h7, 32'h1, 1'b0);
        check_read(uart_pkg::ADDR_RDR, 32'hFF, {24'b0, b}, 1'b0);
        chk_i.end_test("parity");

        set_lcr(6'h06);
        next_byte(b);
        send_frame(b, 1'b0, 1'b0, 1'b0);
        check_read(uart_pkg::ADDR_LSR, 32'h0E,
                   bit_mask(uart_pkg::LSR_FE) | bit_mask(uart_pkg::LSR_DR), 1'b0);
        check_read(uart_pkg::ADDR_RDR, 32'hFF, {24'b0, b}, 1'b0);
        chk_i.end_test("framing");

        next_byte(b);
        next_byte(b2);
        send_frame(b, 1'b0, 1'b0, 1'b1);
        send_frame(b2, 1'b0, 1'b0, 1'b1);
        check_read(uart_pkg::ADDR_LSR, 32'h2E,
                   bit_mask(uart_pkg::LSR_OE) | bit_mask(uart_pkg::LSR_DR), 1'b0);
        check_read(uart_pkg::ADDR_RDR, 32'hFF, {24'b0, b2}, 1'b0);
        chk_i.end_test("overrun");

        // RLS over RDA over THRE
        set_lcr(6'h0E);
        write_reg(uart_pkg::ADDR_IER, 32'h7, 1'b0);
        next_byte(b);
        send_frame(b, 1'b1, ~(^b), 1'b1);
        check_read(uart_pkg::ADDR_IIR, 32'h7, 32'h6, 1'b0);
        check_read(uart_pkg::ADDR_LSR, 32'h06, 32'h06, 1'b0);
        check_read(uart_pkg::ADDR_IIR, 32'h7, 32'h4, 1'b0);
        check_read(uart_pkg::ADDR_RDR, 32'hFF, {24'b0, b}, 1'b0);
        check_read(uart_pkg::ADDR_IIR, 32'h7, 32'h2, 1'b0);
        write_reg(uart_pkg::ADDR_IER, 32'h0, 1'b0);
        check_read(uart_pkg::ADDR_IIR, 32'h7, 32'h1, 1'b0);
        chk_i.end_test("priority");

        repeat (10) @(posedge clk);
        if (chk_i.exp_q.size() != 0)
            $display("some expected APB accesses were never observed by the checker");
        $display("summary: 6 tests, %0d errors, %0d unchecked accesses",
                 chk_i.errors, chk_i.exp_q.size());
        if (chk_i.errors == 0 && chk_i.exp_q.size() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: uart_checker.sv
// APB access checker, tx frame monitor and reference frame function
`timescale 1ns/1ps
module uart_checker #(
    parameter int SYSTEM_FREQUENCY = 100000000,
    parameter int SAMPLING_RATE    = 16
) (
    input logic        clk,
    input logic        preset_n,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pwrite_i,
    input logic [11:0] paddr_i,
    input logic [31:0] pwdata_i,
    input logic [31:0] prdata_i,
    input logic        pready_i,
    input logic        pslverr_i,
    input logic        irq_i,
    input logic        tx_i
);
    // entry layout: err, write, addr, mask, value
    logic [77:0] exp_q[$];
    logic [5:0]  lcr_q;
    int          errors = 0;
    int          test_errors = 0;

    function automatic logic [11:0] expected_frame(input logic [7:0] data, input logic [5:0] lcr);
        logic [11:0] bits;
        bits      = '1;
        bits[0]   = 1'b0;
        bits[8:1] = data;
        // parity makes the ones count even, or odd with PODD
        if (lcr[uart_pkg::LCR_PEN]) bits[9] = (^data) ^ lcr[uart_pkg::LCR_PODD];
        return bits;
    endfunction

    function automatic int frame_len(input logic [5:0] lcr);
        return 10 + int'(lcr[uart_pkg::LCR_PEN]) + int'(lcr[uart_pkg::LCR_STOP2]);
    endfunction

    function automatic int bit_period(input logic [5:0] lcr);
        int rate;
        rate = int'(uart_pkg::BAUD_TABLE[lcr[2:0]]);
        return (SYSTEM_FREQUENCY / (rate * SAMPLING_RATE)) * SAMPLING_RATE;
    endfunction

    task automatic mismatch(input string msg);
        $display("MISMATCH %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic expect_access(input logic wr, input logic [11:0] addr,
                                 input logic [31:0] mask, input logic [31:0] value,
                                 input logic err);
        exp_q.push_back({err, wr, addr, mask, value});
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %s (%0d errors)", name, (test_errors == 0) ? "passed" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic check_access(input logic [77:0] e);
        if (pslverr_i !== e[77])
            mismatch($sformatf("addr %h pslverr %b expected %b", paddr_i, pslverr_i, e[77]));
        if (!pwrite_i && ((prdata_i & e[63:32]) !== e[31:0]))
            mismatch($sformatf("addr %h read %h expected %h under mask %h",
                               paddr_i, prdata_i, e[31:0], e[63:32]));
        if (!pwrite_i && paddr_i == uart_pkg::ADDR_IIR && e[63:32] != 0 && irq_i !== ~e[0])
            mismatch($sformatf("irq %b with IIR expected %h", irq_i, e[2:0]));
    endtask

    always @(posedge clk) begin
        if (!preset_n) begin
            lcr_q <= '0;
        end else if (psel_i && penable_i) begin
            // zero wait states on every access
            if (pready_i !== 1'b1)
                mismatch($sformatf("addr %h pready %b in access phase", paddr_i, pready_i));
            if (pwrite_i && !pslverr_i && paddr_i == uart_pkg::ADDR_LCR) lcr_q <= pwdata_i[5:0];
            if (exp_q.size() > 0 && exp_q[0][76] == pwrite_i && exp_q[0][75:64] == paddr_i)
                check_access(exp_q.pop_front());
        end
    end

    initial begin
        logic [11:0] exp_bits;
        int          n;
        int          bp;
        forever begin
            @(posedge clk);
            if (preset_n && psel_i && penable_i && pwrite_i && paddr_i == uart_pkg::ADDR_TDR) begin
                exp_bits = expected_frame(pwdata_i[7:0], lcr_q);
                n        = frame_len(lcr_q);
                bp       = bit_period(lcr_q);
                @(negedge tx_i);
                // sample in the middle of each bit
                repeat (bp / 2) @(posedge clk);
                for (int i = 0; i < n; i++) begin
                    if (tx_i !== exp_bits[i])
                        mismatch($sformatf("tx bit %0d is %b expected %b", i, tx_i, exp_bits[i]));
                    if (i < n - 1) repeat (bp) @(posedge clk);
                end
            end
        end
    end

endmodule

// File: uart_pkg.sv
// register map, LCR/LSR/IER bit positions, interrupt ids and baud rate table
package uart_pkg;

    localparam logic [11:0] ADDR_TDR = 12'h000;
    localparam logic [11:0] ADDR_RDR = 12'h004;
    localparam logic [11:0] ADDR_LCR = 12'h008;
    localparam logic [11:0] ADDR_LSR = 12'h00C;
    localparam logic [11:0] ADDR_IER = 12'h010;
    localparam logic [11:0] ADDR_IIR = 12'h014;

    // LCR_BAUD is the low bit of the 3-bit baud select field
    localparam int LCR_BAUD  = 0;
    localparam int LCR_PEN   = 3;
    localparam int LCR_PODD  = 4;
    localparam int LCR_STOP2 = 5;

    localparam int LSR_TX_DONE = 0;
    localparam int LSR_DR      = 1;
    localparam int LSR_PE      = 2;
    localparam int LSR_FE      = 3;
    localparam int LSR_THRE    = 4;
    localparam int LSR_OE      = 5;

    localparam int IER_RDA  = 0;
    localparam int IER_THRE = 1;
    localparam int IER_RLS  = 2;

    typedef enum logic [2:0] {
        INTR_NONE = 3'b001,
        INTR_THRE = 3'b010,
        INTR_RDA  = 3'b100,
        INTR_RLS  = 3'b110
    } intr_id_e;

    localparam int unsigned BAUD_TABLE [8] = '{
        9600, 19200, 38400, 57600, 115200, 230400, 460800, 921600
    };

endpackage

// File: uart_properties.sv
// concurrent assertions on the APB error response, the interrupt line and the idle serial line
`timescale 1ns/1ps
module uart_properties (
    input logic       clk,
    input logic       preset_n,
    input logic       psel_i,
    input logic       penable_i,
    input logic       pslverr_i,
    input logic       irq_i,
    input logic       tx_i,
    input logic       tx_busy_i,
    input logic [2:0] ier_i,
    input logic [5:0] lsr_i
);
    a_pslverr_in_access: assert property (@(posedge clk) disable iff (!preset_n)
        pslverr_i |-> (psel_i && penable_i))
        else $error("pslverr raised outside an access phase");

    // irq high exactly when some enabled source is pending
    a_irq_pending: assert property (@(posedge clk) disable iff (!preset_n)
        irq_i == ((ier_i[uart_pkg::IER_RLS] && (lsr_i[uart_pkg::LSR_PE]
                                                || lsr_i[uart_pkg::LSR_FE]
                                                || lsr_i[uart_pkg::LSR_OE]))
                  || (ier_i[uart_pkg::IER_RDA] && lsr_i[uart_pkg::LSR_DR])
                  || (ier_i[uart_pkg::IER_THRE] && lsr_i[uart_pkg::LSR_THRE])))
        else $error("irq does not match the enabled pending interrupt sources");

    // line must rest high between frames
    a_tx_idle_high: assert property (@(posedge clk) disable iff (!preset_n)
        !tx_busy_i |-> tx_i)
        else $error("tx line low while the transmitter is idle");

endmodule

bind apb_uart uart_properties u_props (
    .clk       (clk),
    .preset_n  (preset_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pslverr_i (pslverr_o),
    .irq_i     (irq_o),
    .tx_i      (tx_o),
    .tx_busy_i (tx_busy),
    .ier_i     (ier),
    .lsr_i     (lsr)
);

// File: uart_rx.sv
// oversampling receiver FSM with parity, framing and start bit checks
`timescale 1ns/1ps
module uart_rx #(
    parameter int SAMPLING_RATE = 16
) (
    input  logic       clk,
    input  logic       preset_n,
    input  logic       sample_tick_i,
    input  logic       rx_i,
    input  logic       parity_en_i,
    input  logic       parity_odd_i,
    input  logic       stop2_i,
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o,
    output logic       parity_err_o,
    output logic       frame_err_o
);
    localparam int CNT_W = $clog2(SAMPLING_RATE + 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(SAMPLING_RATE / 2 - 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(SAMPLING_RATE - 1);

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_e;

    rx_state_e        state;
    logic             rx_meta, rx_sync, rx_last;
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_q;
    logic             par_q, par_err_q, second_stop, mid_bit;

    assign mid_bit      = sample_tick_i && (tick_cnt == FULL);
    assign rx_data_o    = shift_q;
    assign parity_err_o = par_err_q;

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            state       <= IDLE;
            rx_last     <= 1'b1;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            shift_q     <= '0;
            par_q       <= 1'b0;
            par_err_q   <= 1'b0;
            second_stop <= 1'b0;
            rx_valid_o  <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (sample_tick_i) rx_last <= rx_sync;
            if (sample_tick_i && state inside {DATA, PARITY, STOP}) begin
                tick_cnt <= mid_bit ? '0 : tick_cnt + 1'b1;
            end
            case (state)
                IDLE: if (sample_tick_i && rx_last && !rx_sync) begin
                    tick_cnt <= '0;
                    state    <= START;
                end
                START: if (sample_tick_i) begin
                    if (tick_cnt == HALF) begin
                        // glitch, line back high by mid start bit
                        tick_cnt    <= '0;
                        bit_cnt     <= '0;
                        par_q       <= parity_odd_i;
                        par_err_q   <= 1'b0;
                        second_stop <= 1'b0;
                        state       <= rx_sync ? IDLE : DATA;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                DATA: if (mid_bit) begin
                    shift_q <= {rx_sync, shift_q[7:1]};
                    par_q   <= par_q ^ rx_sync;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= parity_en_i ? PARITY : STOP;
                end
                PARITY: if (mid_bit) begin
                    par_err_q <= par_q ^ rx_sync;
                    state     <= STOP;
                end
                STOP: if (mid_bit) begin
                    if (!second_stop) begin
                        rx_valid_o  <= 1'b1;
                        frame_err_o <= ~rx_sync;
                    end
                    // second stop bit is skipped, not checked
                    if (stop2_i && !second_stop) second_stop <= 1'b1;
                    else                         state       <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: uart_tx.sv
// serial transmitter FSM with optional parity and one or two stop bits
`timescale 1ns/1ps
module uart_tx (
    input  logic       clk,
    input  logic       preset_n,
    input  logic       bit_tick_i,
    input  logic       tx_start_i,
    input  logic [7:0] tx_data_i,
    input  logic       parity_en_i,
    input  logic       parity_odd_i,
    input  logic       stop2_i,
    output logic       tx_o,
    output logic       tx_busy_o,
    output logic       tx_done_o
);
    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} tx_state_e;

    tx_state_e  state;
    logic [7:0] shift_q;
    logic [2:0] bit_cnt;
    logic       pending, par_q, pen_q, stop2_q, stop_last;

    assign tx_busy_o = pending | (state != IDLE);

    always_ff @(posedge clk or negedge preset_n) begin
        if (!preset_n) begin
            state     <= IDLE;
            shift_q   <= '0;
            bit_cnt   <= '0;
            pending   <= 1'b0;
            par_q     <= 1'b0;
            pen_q     <= 1'b0;
            stop2_q   <= 1'b0;
            stop_last <= 1'b0;
            tx_o      <= 1'b1;
            tx_done_o <= 1'b0;
        end else begin
            tx_done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (pending && bit_tick_i) begin
                        pending <= 1'b0;
                        tx_o    <= 1'b0;
                        state   <= START;
                    end else if (tx_start_i && !pending) begin
                        // frame settings held for the whole frame
                        pending <= 1'b1;
                        shift_q <= tx_data_i;
                        par_q   <= parity_odd_i;
                        pen_q   <= parity_en_i;
                        stop2_q <= stop2_i;
                    end
                end
                START: if (bit_tick_i) begin
                    tx_o    <= shift_q[0];
                    par_q   <= par_q ^ shift_q[0];
                    shift_q <= shift_q >> 1;
                    bit_cnt <= '0;
                    state   <= DATA;
                end
                DATA: if (bit_tick_i) begin
                    if (bit_cnt == 3'd7) begin
                        stop_last <= 1'b0;
                        tx_o      <= pen_q ? par_q : 1'b1;
                        state     <= pen_q ? PARITY : STOP;
                    end else begin
                        tx_o    <= shift_q[0];
                        par_q   <= par_q ^ shift_q[0];
                        shift_q <= shift_q >> 1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                PARITY: if (bit_tick_i) begin
                    tx_o  <= 1'b1;
                    state <= STOP;
                end
                STOP: if (bit_tick_i) begin
                    if (stop2_q && !stop_last) begin
                        stop_last <= 1'b1;
                    end else begin
                        tx_done_o <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule
